// File: ucie_pl_pkg.sv
package ucie_pl_pkg;

    // Stream and buffer sizing
    localparam int NUM_PROTOCOLS = 4;
    localparam int FLIT_WIDTH    = 64;
    localparam int FIFO_DEPTH    = 4;

    // Per-protocol credit limits
    localparam int INIT_CREDITS  = 2;
    localparam int MAX_CREDITS   = 15;

    // One flit as carried on every link
    typedef logic [FLIT_WIDTH-1:0] flit_t;

    // Index into the protocol streams
    typedef logic [$clog2(NUM_PROTOCOLS)-1:0] proto_id_t;

    typedef logic [3:0] credit_t;

    // Occupancy, needs one more code than the depth
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_level_t;

    // Saturating statistics
    typedef logic [15:0] stat_count_t;

    // Layer state machine
    typedef enum logic [1:0] {
        PL_RESET,
        PL_INIT,
        PL_ACTIVE
    } pl_state_t;

endpackage

// File: flit_stream_if.sv
`timescale 1ns/1ps

interface flit_stream_if;
    import ucie_pl_pkg::*;

    flit_t     flit;
    proto_id_t protocol_id;
    logic      valid;
    logic      ready;

    // Producer side
    modport source  (output flit, output protocol_id, output valid, input  ready);

    // Consumer side
    modport sink    (input  flit, input  protocol_id, input  valid, output ready);

    // Passive observer, e.g. statistics
    modport monitor (input  flit, input  protocol_id, input  valid, input  ready);

endinterface

// File: flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    enable,
    input  ucie_pl_pkg::flit_t      in_flit,
    input  logic                    in_valid,
    output logic                    in_ready,
    output ucie_pl_pkg::flit_t      out_flit,
    output logic                    out_valid,
    input  logic                    out_ready,
    output ucie_pl_pkg::fifo_level_t level
);
    import ucie_pl_pkg::*;

    flit_t                          mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]  wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]  rd_ptr;
    fifo_level_t                    count;
    logic                           do_write;
    logic                           do_read;

    // Both directions stall while the stream is disabled
    assign in_ready  = enable && (count != fifo_level_t'(FIFO_DEPTH));
    assign out_valid = enable && (count != '0);
    assign out_flit  = mem[rd_ptr];
    assign level     = count;

    assign do_write = in_valid && in_ready;
    assign do_read  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= in_flit;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: tx_credit_arbiter.sv
`timescale 1ns/1ps

module tx_credit_arbiter (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  ucie_pl_pkg::flit_t                   head_flit [ucie_pl_pkg::NUM_PROTOCOLS],
    input  logic [ucie_pl_pkg::NUM_PROTOCOLS-1:0] head_valid,
    output logic [ucie_pl_pkg::NUM_PROTOCOLS-1:0] head_pop,
    input  logic [ucie_pl_pkg::NUM_PROTOCOLS-1:0] credit_return,
    input  logic                                 link_active,
    flit_stream_if.source                        tx
);
    import ucie_pl_pkg::*;

    credit_t                  credits [NUM_PROTOCOLS];
    logic [NUM_PROTOCOLS-1:0] eligible;
    proto_id_t                last_served;
    proto_id_t                grant_id;
    logic                     grant_any;
    logic                     load;
    logic                     egress_valid;
    flit_t                    egress_flit;
    proto_id_t                egress_id;

    always_comb begin
        for (int i = 0; i < NUM_PROTOCOLS; i++) begin
            eligible[i] = link_active && head_valid[i] && (credits[i] != '0);
        end
    end

    // Round-robin search starting just after the last grant
    always_comb begin
        proto_id_t idx;
        grant_id  = '0;
        grant_any = 1'b0;
        for (int k = 1; k <= NUM_PROTOCOLS; k++) begin
            idx = last_served + proto_id_t'(k);
            if (!grant_any && eligible[idx]) begin
                grant_id  = idx;
                grant_any = 1'b1;
            end
        end
    end

    // Reload when empty or when the current flit leaves on this edge
    assign load = grant_any && (!egress_valid || tx.ready);

    always_comb begin
        head_pop = '0;
        head_pop[grant_id] = load;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            egress_valid <= 1'b0;
            last_served  <= proto_id_t'(NUM_PROTOCOLS - 1);
        end else if (load) begin
            egress_valid <= 1'b1;
            last_served  <= grant_id;
        end else if (tx.ready) begin
            egress_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            egress_flit <= head_flit[grant_id];
            egress_id   <= grant_id;
        end
    end

    // Spend on grant, return from the far side, both at once cancel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PROTOCOLS; i++) begin
                credits[i] <= credit_t'(INIT_CREDITS);
            end
        end else begin
            for (int i = 0; i < NUM_PROTOCOLS; i++) begin
                if (head_pop[i] && !credit_return[i]) begin
                    credits[i] <= credits[i] - 1'b1;
                end else if (credit_return[i] && !head_pop[i] &&
                             (credits[i] != credit_t'(MAX_CREDITS))) begin
                    credits[i] <= credits[i] + 1'b1;
                end
            end
        end
    end

    assign tx.valid       = egress_valid;
    assign tx.flit        = egress_flit;
    assign tx.protocol_id = egress_id;

endmodule

// File: rx_protocol_demux.sv
`timescale 1ns/1ps

module rx_protocol_demux (
    flit_stream_if.sink                          rx,
    output ucie_pl_pkg::flit_t                   fifo_flit,
    output logic [ucie_pl_pkg::NUM_PROTOCOLS-1:0] fifo_valid,
    input  logic [ucie_pl_pkg::NUM_PROTOCOLS-1:0] fifo_ready
);
    import ucie_pl_pkg::*;

    proto_id_t dest;

    assign dest = rx.protocol_id;

    // Flit fans out to all FIFOs, only the addressed one sees valid
    assign fifo_flit = rx.flit;

    always_comb begin
        fifo_valid = '0;
        fifo_valid[dest] = rx.valid;
    end

    // Enable and full are already folded into each FIFO's ready
    assign rx.ready = fifo_ready[dest];

endmodule

// File: pl_status_tracker.sv
`timescale 1ns/1ps

module pl_status_tracker (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [ucie_pl_pkg::NUM_PROTOCOLS-1:0] protocol_enable,
    input  ucie_pl_pkg::fifo_level_t             tx_level [ucie_pl_pkg::NUM_PROTOCOLS],
    input  ucie_pl_pkg::fifo_level_t             rx_level [ucie_pl_pkg::NUM_PROTOCOLS],
    flit_stream_if.monitor                       tx,
    output logic                                 link_active,
    output ucie_pl_pkg::pl_state_t               layer_state,
    output ucie_pl_pkg::stat_count_t             tx_flit_count [ucie_pl_pkg::NUM_PROTOCOLS],
    output logic [ucie_pl_pkg::NUM_PROTOCOLS-1:0] protocol_active
);
    import ucie_pl_pkg::*;

    pl_state_t state;
    pl_state_t state_next;
    logic      tx_fire;

    always_comb begin
        state_next = state;
        case (state)
            PL_RESET:  state_next = PL_INIT;
            PL_INIT:   if (|protocol_enable) state_next = PL_ACTIVE;
            PL_ACTIVE: state_next = PL_ACTIVE;
            default:   state_next = PL_RESET;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PL_RESET;
        end else begin
            state <= state_next;
        end
    end

    assign link_active = (state == PL_ACTIVE);
    assign layer_state = state;
    assign tx_fire     = tx.valid && tx.ready;

    // Per-protocol egress counts, held at all ones
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PROTOCOLS; i++) begin
                tx_flit_count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_PROTOCOLS; i++) begin
                if (tx_fire && (tx.protocol_id == proto_id_t'(i)) &&
                    (tx_flit_count[i] != '1)) begin
                    tx_flit_count[i] <= tx_flit_count[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_PROTOCOLS; i++) begin
            protocol_active[i] = protocol_enable[i] &&
                                 ((tx_level[i] != '0) || (rx_level[i] != '0));
        end
    end

endmodule

// File: ucie_protocol_layer.sv
`timescale 1ns/1ps

module ucie_protocol_layer (
    input  logic                                 clk,
    input  logic                                 rst_n,

    // Upper layer, one stream per protocol
    input  ucie_pl_pkg::flit_t                   ul_tx_flit [ucie_pl_pkg::NUM_PROTOCOLS],
    input  logic [ucie_pl_pkg::NUM_PROTOCOLS-1:0] ul_tx_valid,
    output logic [ucie_pl_pkg::NUM_PROTOCOLS-1:0] ul_tx_ready,
    output ucie_pl_pkg::flit_t                   ul_rx_flit [ucie_pl_pkg::NUM_PROTOCOLS],
    output logic [ucie_pl_pkg::NUM_PROTOCOLS-1:0] ul_rx_valid,
    input  logic [ucie_pl_pkg::NUM_PROTOCOLS-1:0] ul_rx_ready,

    // D2D adapter side
    output ucie_pl_pkg::flit_t                   d2d_tx_flit,
    output logic                                 d2d_tx_valid,
    input  logic                                 d2d_tx_ready,
    output ucie_pl_pkg::proto_id_t               d2d_tx_protocol_id,
    input  ucie_pl_pkg::flit_t                   d2d_rx_flit,
    input  logic                                 d2d_rx_valid,
    output logic                                 d2d_rx_ready,
    input  ucie_pl_pkg::proto_id_t               d2d_rx_protocol_id,

    // Configuration and status
    input  logic [ucie_pl_pkg::NUM_PROTOCOLS-1:0] protocol_enable,
    input  logic [ucie_pl_pkg::NUM_PROTOCOLS-1:0] credit_return,
    output ucie_pl_pkg::pl_state_t               layer_state,
    output ucie_pl_pkg::stat_count_t             tx_flit_count [ucie_pl_pkg::NUM_PROTOCOLS],
    output logic [ucie_pl_pkg::NUM_PROTOCOLS-1:0] protocol_active
);
    import ucie_pl_pkg::*;

    flit_stream_if tx_link ();
    flit_stream_if rx_link ();

    logic                     link_active;
    logic [NUM_PROTOCOLS-1:0] fifo_enable;
    flit_t                    tx_head_flit [NUM_PROTOCOLS];
    logic [NUM_PROTOCOLS-1:0] tx_head_valid;
    logic [NUM_PROTOCOLS-1:0] tx_head_pop;
    fifo_level_t              tx_level [NUM_PROTOCOLS];
    fifo_level_t              rx_level [NUM_PROTOCOLS];
    flit_t                    rx_fifo_flit;
    logic [NUM_PROTOCOLS-1:0] rx_fifo_valid;
    logic [NUM_PROTOCOLS-1:0] rx_fifo_ready;

    assign fifo_enable = {NUM_PROTOCOLS{link_active}} & protocol_enable;

    assign d2d_tx_flit        = tx_link.flit;
    assign d2d_tx_protocol_id = tx_link.protocol_id;
    assign d2d_tx_valid       = tx_link.valid;
    assign tx_link.ready      = d2d_tx_ready;

    assign rx_link.flit        = d2d_rx_flit;
    assign rx_link.protocol_id = d2d_rx_protocol_id;
    assign rx_link.valid       = d2d_rx_valid;
    assign d2d_rx_ready        = rx_link.ready;

    for (genvar i = 0; i < NUM_PROTOCOLS; i++) begin : g_tx_fifo
        flit_fifo u_tx_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .enable    (fifo_enable[i]),
            .in_flit   (ul_tx_flit[i]),
            .in_valid  (ul_tx_valid[i]),
            .in_ready  (ul_tx_ready[i]),
            .out_flit  (tx_head_flit[i]),
            .out_valid (tx_head_valid[i]),
            .out_ready (tx_head_pop[i]),
            .level     (tx_level[i])
        );
    end

    for (genvar i = 0; i < NUM_PROTOCOLS; i++) begin : g_rx_fifo
        flit_fifo u_rx_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .enable    (fifo_enable[i]),
            .in_flit   (rx_fifo_flit),
            .in_valid  (rx_fifo_valid[i]),
            .in_ready  (rx_fifo_ready[i]),
            .out_flit  (ul_rx_flit[i]),
            .out_valid (ul_rx_valid[i]),
            .out_ready (ul_rx_ready[i]),
            .level     (rx_level[i])
        );
    end

    tx_credit_arbiter u_tx_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .head_flit     (tx_head_flit),
        .head_valid    (tx_head_valid),
        .head_pop      (tx_head_pop),
        .credit_return (credit_return),
        .link_active   (link_active),
        .tx            (tx_link)
    );

    rx_protocol_demux u_rx_demux (
        .rx         (rx_link),
        .fifo_flit  (rx_fifo_flit),
        .fifo_valid (rx_fifo_valid),
        .fifo_ready (rx_fifo_ready)
    );

    pl_status_tracker u_status (
        .clk             (clk),
        .rst_n           (rst_n),
        .protocol_enable (protocol_enable),
        .tx_level        (tx_level),
        .rx_level        (rx_level),
        .tx              (tx_link),
        .link_active     (link_active),
        .layer_state     (layer_state),
        .tx_flit_count   (tx_flit_count),
        .protocol_active (protocol_active)
    );

endmodule

// File: ucie_pl_checker.sv
`timescale 1ns/1ps

module ucie_pl_checker (
    input logic                                  clk,
    input logic                                  rst_n,
    input logic                                  d2d_tx_valid,
    input logic                                  d2d_tx_ready,
    input ucie_pl_pkg::flit_t                    d2d_tx_flit,
    input ucie_pl_pkg::proto_id_t                d2d_tx_protocol_id,
    input logic [ucie_pl_pkg::NUM_PROTOCOLS-1:0] ul_tx_ready,
    input logic [ucie_pl_pkg::NUM_PROTOCOLS-1:0] ul_rx_valid,
    input logic                                  d2d_rx_ready,
    input ucie_pl_pkg::proto_id_t                d2d_rx_protocol_id,
    input logic [ucie_pl_pkg::NUM_PROTOCOLS-1:0] protocol_enable,
    input ucie_pl_pkg::pl_state_t                layer_state
);
    import ucie_pl_pkg::*;

    // Egress flit is held until the adapter takes it
    tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
        d2d_tx_valid && !d2d_tx_ready |=>
        d2d_tx_valid && $stable(d2d_tx_flit) && $stable(d2d_tx_protocol_id))
        else $error("d2d_tx flit dropped or changed before ready");

    idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        layer_state != PL_ACTIVE |->
        !(|ul_tx_ready) && !(|ul_rx_valid) && !d2d_rx_ready && !d2d_tx_valid)
        else $error("traffic outside the active layer state");

    disabled_rx: assert property (@(posedge clk) disable iff (!rst_n)
        !protocol_enable[d2d_rx_protocol_id] |-> !d2d_rx_ready)
        else $error("d2d_rx_ready high for a disabled protocol");

endmodule

bind ucie_protocol_layer ucie_pl_checker u_checker (
    .clk                (clk),
    .rst_n              (rst_n),
    .d2d_tx_valid       (d2d_tx_valid),
    .d2d_tx_ready       (d2d_tx_ready),
    .d2d_tx_flit        (d2d_tx_flit),
    .d2d_tx_protocol_id (d2d_tx_protocol_id),
    .ul_tx_ready        (ul_tx_ready),
    .ul_rx_valid        (ul_rx_valid),
    .d2d_rx_ready       (d2d_rx_ready),
    .d2d_rx_protocol_id (d2d_rx_protocol_id),
    .protocol_enable    (protocol_enable),
    .layer_state        (layer_state)
);

// File: tb_ucie_protocol_layer.sv
`timescale 1ns/1ps

module tb_ucie_protocol_layer;
    import ucie_pl_pkg::*;

    logic                     clk;
    logic                     rst_n;
    flit_t                    ul_tx_flit [NUM_PROTOCOLS];
    logic [NUM_PROTOCOLS-1:0] ul_tx_valid;
    logic [NUM_PROTOCOLS-1:0] ul_tx_ready;
    flit_t                    ul_rx_flit [NUM_PROTOCOLS];
    logic [NUM_PROTOCOLS-1:0] ul_rx_valid;
    logic [NUM_PROTOCOLS-1:0] ul_rx_ready;
    flit_t                    d2d_tx_flit;
    logic                     d2d_tx_valid;
    logic                     d2d_tx_ready;
    proto_id_t                d2d_tx_protocol_id;
    flit_t                    d2d_rx_flit;
    logic                     d2d_rx_valid;
    logic                     d2d_rx_ready;
    proto_id_t                d2d_rx_protocol_id;
    logic [NUM_PROTOCOLS-1:0] protocol_enable;
    logic [NUM_PROTOCOLS-1:0] credit_return;
    pl_state_t                layer_state;
    stat_count_t              tx_flit_count [NUM_PROTOCOLS];
    logic [NUM_PROTOCOLS-1:0] protocol_active;

    // Scoreboard state
    flit_t       tx_exp [NUM_PROTOCOLS][$];
    flit_t       rx_exp [NUM_PROTOCOLS][$];
    int          sent_cnt [NUM_PROTOCOLS];
    int          out_cnt [NUM_PROTOCOLS];
    int          rx_in [NUM_PROTOCOLS];
    int          rx_out [NUM_PROTOCOLS];
    int          errors;
    int          test_base;
    int          tests_pass;
    int          tests_fail;
    int          cycles;
    int          cycle_limit;
    int          ready_mode;
    int          rr_left;
    bit          rr_first;
    proto_id_t   prev_id;
    bit          test_open;
    logic [8*24-1:0] test_name;

    ucie_protocol_layer u_dut (.*);

    always #10 clk = ~clk;

    task automatic mismatch(input string sig, input logic [63:0] exp, input logic [63:0] act);
        $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, sig, exp, act);
        errors++;
    endtask

    task automatic problem(input string what);
        $display("Error at t=%0t: %s", $time, what);
        errors++;
    endtask

    task automatic close_test();
        if (test_open) begin
            if (errors == test_base) begin
                $display("test %0s: passed", test_name);
                tests_pass++;
            end else begin
                $display("test %0s: failed with %0d errors", test_name, errors - test_base);
                tests_fail++;
            end
        end
        test_open = 1'b0;
    endtask

    // Ready stall patterns for the adapter and the upper layer
    always @(posedge clk) begin
        #1;
        case (ready_mode)
            0: begin
                d2d_tx_ready <= 1'b0;
                ul_rx_ready  <= '0;
            end
            1: begin
                d2d_tx_ready <= 1'b1;
                ul_rx_ready  <= '1;
            end
            default: begin
                d2d_tx_ready <= $urandom % 2;
                ul_rx_ready  <= NUM_PROTOCOLS'($urandom);
            end
        endcase
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    // Handshakes are sampled mid-cycle where all signals are stable
    always @(negedge clk) begin
        int   held;
        bit   busy;
        flit_t exp;
        if (rst_n) begin
            for (int p = 0; p < NUM_PROTOCOLS; p++) begin
                held = (d2d_tx_valid && d2d_tx_protocol_id == proto_id_t'(p)) ? 1 : 0;
                busy = (sent_cnt[p] - out_cnt[p] - held != 0) || (rx_in[p] != rx_out[p]);
                if (protocol_active[p] != (protocol_enable[p] && busy)) begin
                    mismatch($sformatf("protocol_active[%0d]", p),
                             64'(protocol_enable[p] && busy), 64'(protocol_active[p]));
                end
                if (ul_tx_valid[p] && ul_tx_ready[p]) begin
                    tx_exp[p].push_back(ul_tx_flit[p]);
                    sent_cnt[p]++;
                end
            end
            if (d2d_tx_valid && d2d_tx_ready) begin
                if (tx_exp[d2d_tx_protocol_id].size() == 0) begin
                    problem($sformatf("unexpected d2d_tx flit on protocol %0d",
                                      d2d_tx_protocol_id));
                end else begin
                    exp = tx_exp[d2d_tx_protocol_id].pop_front();
                    if (d2d_tx_flit !== exp) begin
                        mismatch("d2d_tx_flit", exp, d2d_tx_flit);
                    end
                end
                out_cnt[d2d_tx_protocol_id]++;
                if (rr_left > 0) begin
                    if (rr_first) begin
                        rr_first = 1'b0;
                    end else begin
                        if (d2d_tx_protocol_id != proto_id_t'(prev_id + 1'b1)) begin
                            mismatch("d2d_tx_protocol_id", 64'(proto_id_t'(prev_id + 1'b1)),
                                     64'(d2d_tx_protocol_id));
                        end
                        rr_left--;
                    end
                end
                prev_id = d2d_tx_protocol_id;
            end
            if (d2d_rx_valid && d2d_rx_ready) begin
                rx_exp[d2d_rx_protocol_id].push_back(d2d_rx_flit);
                rx_in[d2d_rx_protocol_id]++;
            end
            for (int p = 0; p < NUM_PROTOCOLS; p++) begin
                if (ul_rx_valid[p] && ul_rx_ready[p]) begin
                    if (rx_exp[p].size() == 0) begin
                        problem($sformatf("unexpected ul_rx flit on protocol %0d", p));
                    end else begin
                        exp = rx_exp[p].pop_front();
                        if (ul_rx_flit[p] !== exp) begin
                            mismatch($sformatf("ul_rx_flit[%0d]", p), exp, ul_rx_flit[p]);
                        end
                    end
                    rx_out[p]++;
                end
            end
        end
    end

    // All command tasks start and end 1 ns after a rising edge
    task automatic send_flit(input int p, input flit_t data);
        bit done;
        done = 1'b0;
        ul_tx_flit[p]  = data;
        ul_tx_valid[p] = 1'b1;
        while (!done) begin
            @(negedge clk);
            done = ul_tx_ready[p];
            @(posedge clk);
            #1;
        end
        ul_tx_valid[p] = 1'b0;
    endtask

    task automatic recv_flit(input int p, input flit_t data);
        bit done;
        done = 1'b0;
        d2d_rx_flit        = data;
        d2d_rx_protocol_id = proto_id_t'(p);
        d2d_rx_valid       = 1'b1;
        if (!protocol_enable[p]) begin
            repeat (4) begin
                @(negedge clk);
                if (d2d_rx_ready) begin
                    mismatch("d2d_rx_ready", 64'd0, 64'd1);
                end
                @(posedge clk);
                #1;
            end
        end else begin
            while (!done) begin
                @(negedge clk);
                done = d2d_rx_ready;
                @(posedge clk);
                #1;
            end
        end
        d2d_rx_valid = 1'b0;
    endtask

    task automatic pulse_credit(input int p);
        credit_return[p] = 1'b1;
        @(posedge clk);
        #1;
        credit_return[p] = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_idle();
        @(negedge clk);
        if (d2d_tx_valid !== 1'b0) mismatch("d2d_tx_valid", 0, 64'(d2d_tx_valid));
        if (ul_tx_ready !== '0) mismatch("ul_tx_ready", 0, 64'(ul_tx_ready));
        if (ul_rx_valid !== '0) mismatch("ul_rx_valid", 0, 64'(ul_rx_valid));
        if (d2d_rx_ready !== 1'b0) mismatch("d2d_rx_ready", 0, 64'(d2d_rx_ready));
        @(posedge clk);
        #1;
    endtask

    task automatic run_commands(input int fd);
        logic [8*16-1:0]  cmd;
        logic [8*128-1:0] line;
        logic [63:0]      a;
        logic [63:0]      b;
        int               r;
        while ($fscanf(fd, "%s", cmd) == 1) begin
            case (cmd)
                "#": r = $fgets(line, fd);
                "P": begin
                    close_test();
                    r = $fscanf(fd, "%s", test_name);
                    test_base = errors;
                    test_open = 1'b1;
                end
                "A": check_idle();
                "E": begin
                    r = $fscanf(fd, "%h", a);
                    protocol_enable = NUM_PROTOCOLS'(a);
                end
                "T": begin
                    r = $fscanf(fd, "%h", a);
                    ready_mode = int'(a);
                end
                "S": begin
                    r = $fscanf(fd, "%h %h", a, b);
                    send_flit(int'(a), b);
                end
                "R": begin
                    r = $fscanf(fd, "%h %h", a, b);
                    recv_flit(int'(a), b);
                end
                "C": begin
                    r = $fscanf(fd, "%h", a);
                    pulse_credit(int'(a));
                end
                "W": begin
                    r = $fscanf(fd, "%d", a);
                    wait_cycles(int'(a));
                end
                "G": begin
                    r = $fscanf(fd, "%d", a);
                    rr_left  = int'(a);
                    rr_first = 1'b1;
                end
                "L": begin
                    r = $fscanf(fd, "%h", a);
                    if (layer_state !== pl_state_t'(a)) begin
                        mismatch("layer_state", a, 64'(layer_state));
                    end
                end
                "X": begin
                    r = $fscanf(fd, "%h %d", a, b);
                    if (out_cnt[a] != int'(b)) begin
                        mismatch("d2d_tx handshakes", b, 64'(out_cnt[a]));
                    end
                    if (tx_flit_count[a] !== stat_count_t'(out_cnt[a])) begin
                        mismatch($sformatf("tx_flit_count[%0d]", a), 64'(out_cnt[a]),
                                 64'(tx_flit_count[a]));
                    end
                end
                default: problem($sformatf("unknown command %0s in pl_input.txt", cmd));
            endcase
        end
    endtask

    initial begin
        int               fd;
        int               lines;
        logic [8*128-1:0] line;
        clk                = 1'b0;
        rst_n              = 1'b0;
        ul_tx_valid        = '0;
        d2d_tx_ready       = 1'b0;
        ul_rx_ready        = '0;
        d2d_rx_flit        = '0;
        d2d_rx_valid       = 1'b0;
        d2d_rx_protocol_id = '0;
        protocol_enable    = '0;
        credit_return      = '0;
        for (int p = 0; p < NUM_PROTOCOLS; p++) begin
            ul_tx_flit[p] = '0;
        end
        ready_mode = 1;
        void'($urandom(32'h585c));

        // Timeout budget scales with the stimulus length
        lines = 0;
        fd = $fopen("pl_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open pl_input.txt");
            $display("Test FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) lines++;
            end
            $fclose(fd);
            cycle_limit = 20 * lines;

            repeat (2) @(posedge clk);
            #1;
            rst_n = 1'b1;

            fd = $fopen("pl_input.txt", "r");
            run_commands(fd);
            $fclose(fd);
            close_test();

            for (int p = 0; p < NUM_PROTOCOLS; p++) begin
                if (tx_exp[p].size() != 0 || rx_exp[p].size() != 0) begin
                    problem($sformatf("flits on protocol %0d never arrived", p));
                end
                if (tx_flit_count[p] !== stat_count_t'(out_cnt[p])) begin
                    mismatch($sformatf("tx_flit_count[%0d]", p), 64'(out_cnt[p]),
                             64'(tx_flit_count[p]));
                end
            end
            $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                     tests_pass, tests_fail, errors);
            if (errors == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule

// File: pl_input.txt
# Commands: P name, A idle check, E enable_mask, T ready_mode(0 low 1 high 2 random)
# S proto flit, R proto flit, C proto, W cycles, G grants, L state, X proto count
P reset_idle
A
L 1
E f
W 2
L 2
P round_robin
T 0
S 0 a0
S 0 a1
S 1 b0
S 1 b1
S 2 c0
S 2 c1
S 3 d0
S 3 d1
G 7
T 1
W 20
P credit_limit
S 0 a2
W 10
X 0 2
C 0
W 10
X 0 3
P ordered_stall
T 2
C 1
C 1
C 1
C 1
S 1 b2
S 1 b3
S 1 b4
S 1 b5
W 40
X 1 6
P rx_steer
R 0 e0
R 2 e1
R 0 e2
R 3 e3
W 20
E 7
R 3 e4
W 10

// File: files.f
ucie_pl_pkg.sv
flit_stream_if.sv
flit_fifo.sv
tx_credit_arbiter.sv
rx_protocol_demux.sv
pl_status_tracker.sv
ucie_protocol_layer.sv
ucie_pl_checker.sv
tb_ucie_protocol_layer.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ucie_protocol_layer -f files.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1
grep -qx "Test OK" sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
